// ==== src/rv_core_pkg.sv ====
package rv_core_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;       // data word and byte address
  typedef logic [4:0]      reg_addr_t;
  typedef logic [3:0]      byte_sel_t;   // one bit per byte lane
  typedef logic [6:0]      opcode_t;

  // major opcodes of the kept subset
  localparam opcode_t op_imm    = 7'b001_0011;
  localparam opcode_t op_lui    = 7'b011_0111;
  localparam opcode_t op_auipc  = 7'b001_0111;
  localparam opcode_t op_jal    = 7'b110_1111;
  localparam opcode_t op_jalr   = 7'b110_0111;
  localparam opcode_t op_load   = 7'b000_0011;
  localparam opcode_t op_store  = 7'b010_0011;
  localparam opcode_t op_system = 7'b111_0011;   // only ebreak is decoded

  // access size and sign, as carried in funct3
  localparam logic [2:0] f3_byte   = 3'b000;
  localparam logic [2:0] f3_half   = 3'b001;
  localparam logic [2:0] f3_word   = 3'b010;
  localparam logic [2:0] f3_byte_u = 3'b100;
  localparam logic [2:0] f3_half_u = 3'b101;

  // register write-back source
  typedef enum logic [1:0] {
    wb_src_alu  = 2'd0,   // adder result
    wb_src_pc4  = 2'd1,   // link address
    wb_src_load = 2'd2    // extended load data
  } wb_src_t;

  // first adder operand
  typedef enum logic {
    opa_rs1 = 1'b0,
    opa_pc  = 1'b1
  } operand_a_t;

endpackage

// ==== src/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder (
  input  rv_core_pkg::word_t      inst,
  output rv_core_pkg::reg_addr_t  rs1,
  output rv_core_pkg::reg_addr_t  rs2,
  output rv_core_pkg::reg_addr_t  rd,
  output logic [2:0]              funct3,
  output rv_core_pkg::word_t      imm,
  output rv_core_pkg::operand_a_t operand_a,
  output rv_core_pkg::wb_src_t    wb_src,
  output logic                    reg_write,
  output logic                    mem_read,
  output logic                    mem_write,
  output logic                    jump,
  output logic                    is_ebreak
);
  import rv_core_pkg::*;

  opcode_t opcode;
  word_t   imm_i;
  word_t   imm_s;
  word_t   imm_u;
  word_t   imm_j;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign rs2    = inst[24:20];
  assign rd     = inst[11:7];

  // immediates, all sign-extended from bit 31
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000};   // already shifted up
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    rs1       = inst[19:15];
    imm       = '0;
    operand_a = opa_rs1;
    wb_src    = wb_src_alu;
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    jump      = 1'b0;
    is_ebreak = 1'b0;

    case (opcode)
      op_imm: begin   // every op-imm acts as addi
        imm       = imm_i;
        reg_write = 1'b1;
      end
      op_lui: begin
        rs1       = '0;   // x0 + imm passes the immediate through
        imm       = imm_u;
        reg_write = 1'b1;
      end
      op_auipc: begin
        imm       = imm_u;
        operand_a = opa_pc;
        reg_write = 1'b1;
      end
      op_jal: begin
        imm       = imm_j;
        operand_a = opa_pc;
        wb_src    = wb_src_pc4;
        reg_write = 1'b1;
        jump      = 1'b1;
      end
      op_jalr: begin
        imm       = imm_i;
        wb_src    = wb_src_pc4;
        reg_write = 1'b1;
        jump      = 1'b1;
      end
      op_load: begin
        imm       = imm_i;
        wb_src    = wb_src_load;
        reg_write = 1'b1;
        mem_read  = 1'b1;
      end
      op_store: begin
        imm       = imm_s;
        mem_write = 1'b1;
      end
      op_system: begin
        is_ebreak = 1'b1;
      end
      default: begin
        // unknown opcode retires as a no-op
        reg_write = 1'b0;
      end
    endcase
  end

endmodule

// ==== src/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
  input  logic                   clk,
  input  rv_core_pkg::reg_addr_t rs1,
  input  rv_core_pkg::reg_addr_t rs2,
  input  rv_core_pkg::reg_addr_t rd,
  input  rv_core_pkg::word_t     wdata,
  input  logic                   wen,
  output rv_core_pkg::word_t     rs1_data,
  output rv_core_pkg::word_t     rs2_data
);
  import rv_core_pkg::*;

  word_t regs [32];

  // x0 is never written
  always_ff @(posedge clk) begin
    if (wen && (rd != '0)) begin
      regs[rd] <= wdata;
    end
  end

  // reads are combinational, x0 forced to zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== src/rv_lsu.sv ====
`timescale 1ns/1ps

module rv_lsu (
  input  logic                   clk,
  input  logic                   reset,
  input  rv_core_pkg::word_t     addr,
  input  rv_core_pkg::word_t     store_data,
  input  logic [2:0]             funct3,
  input  logic                   mem_read,
  input  logic                   mem_write,
  input  logic                   halted,
  output rv_core_pkg::word_t     load_data,
  output logic                   mem_busy,
  output rv_core_pkg::word_t     wb_adr,
  output rv_core_pkg::word_t     wb_dat_w,
  output rv_core_pkg::byte_sel_t wb_sel,
  output logic                   wb_we,
  output logic                   wb_cyc,
  output logic                   wb_stb,
  input  rv_core_pkg::word_t     wb_dat_r,
  input  logic                   wb_ack
);
  import rv_core_pkg::*;

  logic        bus_enable;
  logic        mem_req;
  logic [7:0]  lane_byte;
  logic [15:0] lane_half;

  // low through reset, high from the first cycle after
  always_ff @(posedge clk) begin
    if (reset) begin
      bus_enable <= 1'b0;
    end else begin
      bus_enable <= 1'b1;
    end
  end

  assign mem_req = (mem_read | mem_write) & ~halted;

  // classic cycle, cyc and stb move together
  assign wb_cyc = mem_req & bus_enable;
  assign wb_stb = wb_cyc;
  assign wb_we  = mem_write & wb_cyc;
  assign wb_adr = {addr[31:2], 2'b00};   // word aligned

  // pc and register write wait for the ack edge
  assign mem_busy = mem_req & ~(wb_cyc & wb_ack);

  // byte lanes from size and low address bits
  always_comb begin
    case (funct3)
      f3_byte, f3_byte_u: wb_sel = 4'b0001 << addr[1:0];
      f3_half, f3_half_u: begin
        if (addr[0]) begin
          wb_sel = 4'b0000;   // misaligned half
        end else begin
          wb_sel = addr[1] ? 4'b1100 : 4'b0011;
        end
      end
      f3_word: wb_sel = (addr[1:0] == 2'b00) ? 4'b1111 : 4'b0000;
      default: wb_sel = 4'b0000;
    endcase
  end

  // store data copied into every lane the select may pick
  always_comb begin
    case (funct3)
      f3_byte: wb_dat_w = {4{store_data[7:0]}};
      f3_half: wb_dat_w = {2{store_data[15:0]}};
      default: wb_dat_w = store_data;
    endcase
  end

  assign lane_byte = wb_dat_r[{addr[1:0], 3'b000} +: 8];
  assign lane_half = addr[1] ? wb_dat_r[31:16] : wb_dat_r[15:0];

  // extend by funct3
  always_comb begin
    case (funct3)
      f3_byte:   load_data = {{24{lane_byte[7]}}, lane_byte};
      f3_byte_u: load_data = {24'h00_0000, lane_byte};
      f3_half:   load_data = {{16{lane_half[15]}}, lane_half};
      f3_half_u: load_data = {16'h0000, lane_half};
      f3_word:   load_data = wb_dat_r;
      default:   load_data = '0;
    endcase
  end

endmodule

// ==== src/rv_pc_unit.sv ====
`timescale 1ns/1ps

module rv_pc_unit #(
  parameter rv_core_pkg::word_t reset_vector = 32'h8000_0000
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               jump,
  input  rv_core_pkg::word_t target,
  input  logic               mem_busy,
  input  logic               is_ebreak,
  output rv_core_pkg::word_t pc,
  output rv_core_pkg::word_t pc_plus4,
  output logic               halted
);
  import rv_core_pkg::*;

  word_t next_pc;

  assign pc_plus4 = pc + 32'd4;

  // bit 0 cleared for jalr, jal targets are even anyway
  assign next_pc = jump ? {target[31:1], 1'b0} : pc_plus4;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc     <= reset_vector;
      halted <= 1'b0;
    end else if (!halted) begin
      if (is_ebreak) begin
        halted <= 1'b1;   // pc stays on the ebreak
      end else if (!mem_busy) begin
        pc <= next_pc;
      end
    end
  end

endmodule

// ==== src/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top #(
  parameter rv_core_pkg::word_t reset_vector = 32'h8000_0000
) (
  input  logic                   clk,
  input  logic                   reset,
  input  rv_core_pkg::word_t     inst,
  output rv_core_pkg::word_t     pc,
  output rv_core_pkg::word_t     wb_adr,
  output rv_core_pkg::word_t     wb_dat_w,
  output rv_core_pkg::byte_sel_t wb_sel,
  output logic                   wb_we,
  output logic                   wb_cyc,
  output logic                   wb_stb,
  input  rv_core_pkg::word_t     wb_dat_r,
  input  logic                   wb_ack,
  output logic                   halted
);
  import rv_core_pkg::*;

  reg_addr_t  rs1;
  reg_addr_t  rs2;
  reg_addr_t  rd;
  logic [2:0] funct3;
  word_t      imm;
  operand_a_t operand_a;
  wb_src_t    wb_src;
  logic       reg_write;
  logic       mem_read;
  logic       mem_write;
  logic       jump;
  logic       is_ebreak;
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      add_a;
  word_t      add_result;
  word_t      pc_plus4;
  word_t      load_data;
  logic       mem_busy;
  word_t      wdata;
  logic       reg_wen;

  rv_decoder i_decoder (
    .inst      (inst),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .funct3    (funct3),
    .imm       (imm),
    .operand_a (operand_a),
    .wb_src    (wb_src),
    .reg_write (reg_write),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .jump      (jump),
    .is_ebreak (is_ebreak)
  );

  // single adder for addresses, targets and addi/lui/auipc results
  assign add_a      = (operand_a == opa_pc) ? pc : rs1_data;
  assign add_result = add_a + imm;

  always_comb begin
    case (wb_src)
      wb_src_pc4:  wdata = pc_plus4;   // link
      wb_src_load: wdata = load_data;
      default:     wdata = add_result;
    endcase
  end

  // no writes while a transfer waits, after halt, or during reset
  assign reg_wen = reg_write & ~mem_busy & ~halted & ~reset;

  rv_regfile i_regfile (
    .clk      (clk),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .wdata    (wdata),
    .wen      (reg_wen),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_lsu i_lsu (
    .clk        (clk),
    .reset      (reset),
    .addr       (add_result),
    .store_data (rs2_data),
    .funct3     (funct3),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .halted     (halted),
    .load_data  (load_data),
    .mem_busy   (mem_busy),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_sel     (wb_sel),
    .wb_we      (wb_we),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack)
  );

  rv_pc_unit #(
    .reset_vector (reset_vector)
  ) i_pc_unit (
    .clk       (clk),
    .reset     (reset),
    .jump      (jump),
    .target    (add_result),
    .mem_busy  (mem_busy),
    .is_ebreak (is_ebreak),
    .pc        (pc),
    .pc_plus4  (pc_plus4),
    .halted    (halted)
  );

endmodule

// ==== tests/tb_program.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int prog_len  = 40;
localparam int max_store = 32;
localparam int max_pc    = 64;
localparam word_t ebreak_word = 32'h0010_0073;

word_t     prog       [prog_len];
word_t     exp_st_adr [max_store];
word_t     exp_st_dat [max_store];
byte_sel_t exp_st_sel [max_store];
word_t     exp_pc     [max_pc];
int        st_count;
int        pc_count;

function automatic word_t encode_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                   reg_addr_t rd, opcode_t op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic word_t encode_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
endfunction

function automatic word_t encode_u(logic [19:0] imm, reg_addr_t rd, opcode_t op);
  return {imm, rd, op};
endfunction

function automatic word_t encode_j(logic [20:0] imm, reg_addr_t rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
endfunction

task automatic add_store(word_t adr, word_t dat, byte_sel_t sel);
  exp_st_adr[st_count] = adr;
  exp_st_dat[st_count] = dat;
  exp_st_sel[st_count] = sel;
  st_count++;
endtask

task automatic add_pc_range(int first, int last);
  for (int i = first; i <= last; i++) begin
    exp_pc[pc_count] = reset_vector + 32'(i * 4);
    pc_count++;
  end
endtask

// program and expected traffic, x1 holds the data base 0x1000
task automatic load_tables();
  prog[0]  = encode_u(20'h00001, 5'd1, op_lui);
  prog[1]  = encode_i(12'h123, 5'd0, 3'b000, 5'd2, op_imm);
  prog[2]  = encode_s(12'd0, 5'd2, 5'd1, f3_word);
  prog[3]  = encode_u(20'habcde, 5'd3, op_lui);
  prog[4]  = encode_s(12'd4, 5'd3, 5'd1, f3_word);
  prog[5]  = encode_u(20'h00002, 5'd4, op_auipc);
  prog[6]  = encode_s(12'd8, 5'd4, 5'd1, f3_word);
  prog[7]  = encode_i(12'hffb, 5'd2, 3'b000, 5'd5, op_imm);   // -5
  prog[8]  = encode_s(12'd12, 5'd5, 5'd1, f3_word);
  prog[9]  = encode_i(12'h020, 5'd1, f3_byte, 5'd6, op_load);
  prog[11] = encode_i(12'h021, 5'd1, f3_byte, 5'd6, op_load);
  prog[13] = encode_i(12'h022, 5'd1, f3_byte_u, 5'd6, op_load);
  prog[15] = encode_i(12'h023, 5'd1, f3_byte_u, 5'd6, op_load);
  prog[17] = encode_i(12'h020, 5'd1, f3_half, 5'd6, op_load);
  prog[19] = encode_i(12'h022, 5'd1, f3_half_u, 5'd6, op_load);
  prog[21] = encode_i(12'h022, 5'd1, f3_half, 5'd6, op_load);
  prog[23] = encode_i(12'h020, 5'd1, f3_word, 5'd6, op_load);
  for (int i = 10; i <= 24; i += 2) begin
    prog[i] = encode_s(12'd16, 5'd6, 5'd1, f3_word);   // store each load back
  end
  prog[25] = encode_s(12'd20, 5'd2, 5'd1, f3_byte);
  prog[26] = encode_s(12'd21, 5'd2, 5'd1, f3_byte);
  prog[27] = encode_s(12'd22, 5'd2, 5'd1, f3_byte);
  prog[28] = encode_s(12'd23, 5'd2, 5'd1, f3_byte);
  prog[29] = encode_s(12'd24, 5'd3, 5'd1, f3_half);
  prog[30] = encode_s(12'd26, 5'd3, 5'd1, f3_half);
  prog[31] = encode_j(21'd12, 5'd7);
  prog[32] = ebreak_word;   // skipped by jal
  prog[33] = ebreak_word;
  prog[34] = encode_s(12'd28, 5'd7, 5'd1, f3_word);
  prog[35] = encode_u(20'h00000, 5'd8, op_auipc);
  prog[36] = encode_i(12'd13, 5'd8, 3'b000, 5'd9, op_jalr);   // odd target
  prog[37] = ebreak_word;   // skipped by jalr
  prog[38] = encode_s(12'd0, 5'd9, 5'd1, f3_word);
  prog[39] = ebreak_word;

  st_count = 0;
  add_store(32'h0000_1000, 32'h0000_0123, 4'b1111);
  add_store(32'h0000_1004, 32'habcd_e000, 4'b1111);
  add_store(32'h0000_1008, 32'h8000_2014, 4'b1111);
  add_store(32'h0000_100c, 32'h0000_011e, 4'b1111);
  add_store(32'h0000_1010, 32'hffff_fff5, 4'b1111);   // lb  +0
  add_store(32'h0000_1010, 32'hffff_ffc6, 4'b1111);   // lb  +1
  add_store(32'h0000_1010, 32'h0000_007b, 4'b1111);   // lbu +2
  add_store(32'h0000_1010, 32'h0000_008a, 4'b1111);   // lbu +3
  add_store(32'h0000_1010, 32'hffff_c6f5, 4'b1111);   // lh  +0
  add_store(32'h0000_1010, 32'h0000_8a7b, 4'b1111);   // lhu +2
  add_store(32'h0000_1010, 32'hffff_8a7b, 4'b1111);   // lh  +2
  add_store(32'h0000_1010, 32'h8a7b_c6f5, 4'b1111);   // lw
  add_store(32'h0000_1014, 32'h2323_2323, 4'b0001);
  add_store(32'h0000_1014, 32'h2323_2323, 4'b0010);
  add_store(32'h0000_1014, 32'h2323_2323, 4'b0100);
  add_store(32'h0000_1014, 32'h2323_2323, 4'b1000);
  add_store(32'h0000_1018, 32'he000_e000, 4'b0011);
  add_store(32'h0000_1018, 32'he000_e000, 4'b1100);
  add_store(32'h0000_101c, 32'h8000_0080, 4'b1111);   // jal link
  add_store(32'h0000_1000, 32'h8000_0094, 4'b1111);   // jalr link

  pc_count = 0;
  add_pc_range(0, 31);
  add_pc_range(34, 36);
  add_pc_range(38, 39);
endtask

`endif

// ==== tests/tb_rv_core_top.sv ====
`timescale 1ns/1ps

module tb_rv_core_top;
  import rv_core_pkg::*;

  localparam word_t reset_vector = 32'h8000_0000;
  localparam int    load_count   = 8;

  `include "tb_program.svh"

  localparam int run_cycles = prog_len * 5 + 16 + 20 + 20;

  logic      clk;
  logic      reset;
  word_t     inst;
  word_t     pc;
  word_t     wb_adr;
  word_t     wb_dat_w;
  byte_sel_t wb_sel;
  logic      wb_we;
  logic      wb_cyc;
  logic      wb_stb;
  word_t     wb_dat_r;
  logic      wb_ack;
  logic      halted;

  word_t dmem [16];
  int    mismatches;
  int    failures;
  int    st_seen;
  int    ld_seen;
  int    pc_seen;
  int    waits;
  logic  pc_started;
  word_t last_pc;
  word_t halt_pc;

  rv_core_top #(
    .reset_vector (reset_vector)
  ) i_dut (
    .clk      (clk),
    .reset    (reset),
    .inst     (inst),
    .pc       (pc),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_sel   (wb_sel),
    .wb_we    (wb_we),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .halted   (halted)
  );

  always #10 clk = ~clk;

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_sel(string name, byte_sel_t got, byte_sel_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      mismatches++;
    end
  endtask

  // instruction fetch by pc, plus the pc trace
  always @(negedge clk) begin
    word_t off;
    int    idx;
    off = pc - reset_vector;
    idx = int'(off >> 2);
    if (off[1:0] == 2'b00 && idx >= 0 && idx < prog_len) begin
      inst = prog[idx];
    end else begin
      inst = ebreak_word;   // off the program halts the core
    end
    if (!pc_started || pc != last_pc) begin
      if (pc_seen < pc_count) begin
        check_word("pc", pc, exp_pc[pc_seen]);
      end else begin
        $display("pc moved to %h after the expected sequence ended", pc);
        failures++;
      end
      pc_seen++;
      pc_started = 1'b1;
      last_pc = pc;
    end
  end

  // Wishbone slave with 0 to 3 wait states
  always @(negedge clk) begin
    int i;
    #2;
    if (reset) begin
      wb_ack = 1'b0;
      waits = $urandom % 4;
    end else if (wb_ack) begin
      wb_ack = 1'b0;   // transfer done on the last edge
      waits = $urandom % 4;
    end else if (wb_cyc && wb_stb) begin
      if (waits > 0) begin
        waits--;
      end else begin
        i = int'(wb_adr[5:2]);
        if (wb_we) begin
          if (st_seen < st_count) begin
            check_word("wb_adr", wb_adr, exp_st_adr[st_seen]);
            check_word("wb_dat_w", wb_dat_w, exp_st_dat[st_seen]);
            check_sel("wb_sel", wb_sel, exp_st_sel[st_seen]);
          end else begin
            $display("unexpected store to %h at %0t", wb_adr, $time);
            failures++;
          end
          for (int b = 0; b < 4; b++) begin
            if (wb_sel[b]) begin
              dmem[i][8*b +: 8] = wb_dat_w[8*b +: 8];
            end
          end
          st_seen++;
        end else begin
          wb_dat_r = dmem[i];
          ld_seen++;
        end
        wb_ack = 1'b1;
      end
    end
  end

  initial begin
    #(run_cycles * 20);
    $display("timeout after %0d cycles, the core never finished the program", run_cycles);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    void'($urandom(32'h8996));
    clk        = 1'b0;
    reset      = 1'b1;
    inst       = ebreak_word;
    wb_dat_r   = '0;
    wb_ack     = 1'b0;
    mismatches = 0;
    failures   = 0;
    st_seen    = 0;
    ld_seen    = 0;
    pc_seen    = 0;
    pc_started = 1'b0;
    last_pc    = '0;
    halt_pc    = '0;
    load_tables();
    for (int k = 0; k < 16; k++) begin
      dmem[k] = (32'h0000_1000 + 32'(k * 4)) ^ 32'hc3a5_5a00;
    end
    dmem[8] = 32'h8a7b_c6f5;   // load source at 0x1020

    repeat (16) begin
      @(negedge clk);
      check_word("pc", pc, reset_vector);
      check_flag("wb_cyc", wb_cyc, 1'b0);
      check_flag("wb_stb", wb_stb, 1'b0);
      check_flag("wb_we", wb_we, 1'b0);
      check_flag("halted", halted, 1'b0);
    end
    reset = 1'b0;
    // first cycle with reset low, nothing retired yet
    check_word("pc", pc, reset_vector);
    check_flag("wb_cyc", wb_cyc, 1'b0);
    check_flag("halted", halted, 1'b0);
    @(negedge clk);
    check_word("pc", pc, reset_vector + 32'd4);   // lui retires in one cycle
    check_flag("halted", halted, 1'b0);

    while (!halted) begin
      @(negedge clk);
    end
    halt_pc = pc;
    repeat (20) begin
      @(negedge clk);
      check_word("pc", pc, halt_pc);
      check_flag("wb_cyc", wb_cyc, 1'b0);
      check_flag("wb_stb", wb_stb, 1'b0);
      check_flag("halted", halted, 1'b1);
    end
    check_word("pc", pc, reset_vector + 32'h9c);

    if (st_seen != st_count) begin
      $display("saw %0d store transfers, %0d expected", st_seen, st_count);
      failures++;
    end
    if (ld_seen != load_count) begin
      $display("saw %0d load transfers, %0d expected", ld_seen, load_count);
      failures++;
    end
    if (pc_seen != pc_count) begin
      $display("pc visited %0d addresses, %0d expected", pc_seen, pc_count);
      failures++;
    end

    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== rv_core_top.f ====
+incdir+tests
src/rv_core_pkg.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_lsu.sv
src/rv_pc_unit.sv
src/rv_core_top.sv
tests/tb_rv_core_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the core testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_rv_core_top \
  -f rv_core_top.f -o sim_rv_core_top --Mdir obj_dir \
  && ./obj_dir/sim_rv_core_top > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "^TEST PASS$" sim.log && exit 0 || exit 1
